/* sparce_cfg_pkg.sv */
// ------------------------------
// processor-side widths: data words, pcs and register indices
// ------------------------------

package sparce_cfg_pkg;

  // base widths of the core this front end sits in
  localparam int WORD_W    = 32;
  localparam int PC_W      = 32;
  localparam int REG_IDX_W = 5;

  // number of architectural integer registers
  localparam int NUM_REGS = 1 << REG_IDX_W;

  // store data and writeback data
  typedef logic [WORD_W-1:0] word_t;

  // byte address on the fetch side
  typedef logic [PC_W-1:0] pc_t;

  // architectural register index
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // bytes per instruction, used when stepping the pc
  localparam int INST_BYTES = 4;

endpackage

/* sparce_sasa_pkg.sv */
// ------------------------------
// sasa entry fields, skip condition and config word layout
// ------------------------------

package sparce_sasa_pkg;

  localparam int SASA_PC_W  = 16;
  localparam int SKIP_CNT_W = 5;

  // word address of the instruction ahead of the block, pc[17:2]
  typedef logic [SASA_PC_W-1:0] sasa_pc_t;

  // instructions to jump over
  typedef logic [SKIP_CNT_W-1:0] skip_cnt_t;

  // how the two source zero flags combine
  typedef logic sasa_cond_t;

  localparam sasa_cond_t SASA_COND_OR  = 1'b0;
  localparam sasa_cond_t SASA_COND_AND = 1'b1;

  // field positions inside the stored configuration word
  localparam int CFG_PREV_PC_MSB = 31;
  localparam int CFG_PREV_PC_LSB = 16;
  localparam int CFG_RS1_MSB     = 15;
  localparam int CFG_RS1_LSB     = 11;
  localparam int CFG_RS2_MSB     = 10;
  localparam int CFG_RS2_LSB     = 6;
  localparam int CFG_COND_BIT    = 5;
  localparam int CFG_CNT_MSB     = 4;
  localparam int CFG_CNT_LSB     = 0;

endpackage

/* sparce_sasa_table.sv */
// ------------------------------
// set-associative sasa table, lru fill from snooped stores, pc lookup
// ------------------------------
`timescale 1ns/10ps

module sparce_sasa_table import sparce_cfg_pkg::*, sparce_sasa_pkg::*; #(
  parameter int  SASA_ENTRIES = 16,
  parameter int  SASA_SETS    = 2,
  parameter pc_t SASA_ADDR    = 32'h1000
) (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       sasa_enable,
  input  logic       st_wen,
  input  pc_t        st_addr,
  input  word_t      st_data,
  input  pc_t        pc,
  output logic       hit,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output sasa_cond_t condition,
  output skip_cnt_t  insts_to_skip
);

  // rows per way, SASA_SETS is the associativity
  localparam int DEPTH = SASA_ENTRIES / SASA_SETS;
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int USE_W = (SASA_SETS > 1) ? $clog2(SASA_SETS) : 1;

  typedef logic [IDX_W-1:0] idx_t;
  // usage 0 is most recent, SASA_SETS-1 is the next victim
  typedef logic [USE_W-1:0] usage_t;

  // control state
  logic       valid_q [SASA_SETS][DEPTH];
  usage_t     usage_q [SASA_SETS][DEPTH];
  // entry payload, full word address kept as the tag
  sasa_pc_t   tag_q   [SASA_SETS][DEPTH];
  reg_idx_t   rs1_q   [SASA_SETS][DEPTH];
  reg_idx_t   rs2_q   [SASA_SETS][DEPTH];
  sasa_cond_t cond_q  [SASA_SETS][DEPTH];
  skip_cnt_t  cnt_q   [SASA_SETS][DEPTH];

  // decoded store word
  sasa_pc_t   st_prev_pc;
  reg_idx_t   st_rs1;
  reg_idx_t   st_rs2;
  sasa_cond_t st_cond;
  skip_cnt_t  st_cnt;
  idx_t       st_idx;
  logic       st_fill;
  logic [SASA_SETS-1:0] victim;

  // lookup side
  sasa_pc_t pc_word;
  idx_t     pc_idx;
  usage_t   hit_way;
  logic [SASA_SETS-1:0] hit_vec;

  assign st_prev_pc = st_data[CFG_PREV_PC_MSB:CFG_PREV_PC_LSB];
  assign st_rs1     = st_data[CFG_RS1_MSB:CFG_RS1_LSB];
  assign st_rs2     = st_data[CFG_RS2_MSB:CFG_RS2_LSB];
  assign st_cond    = st_data[CFG_COND_BIT];
  assign st_cnt     = st_data[CFG_CNT_MSB:CFG_CNT_LSB];
  // set index is the low bits of the word address
  assign st_idx     = idx_t'(st_prev_pc % DEPTH);

  // a lookup hit takes the lru port, so an overlapping store is lost
  assign st_fill = sasa_enable && st_wen && (st_addr == SASA_ADDR) && !hit;

  // drop the byte offset
  assign pc_word = sasa_pc_t'(pc >> 2);
  assign pc_idx  = idx_t'(pc_word % DEPTH);

  // oldest way in the target row gets replaced
  always_comb begin
    for (int w = 0; w < SASA_SETS; w++) begin
      victim[w] = (usage_q[w][st_idx] == usage_t'(SASA_SETS - 1));
    end
  end

  // tag compare across all ways of the indexed row
  always_comb begin
    hit_vec       = '0;
    hit_way       = '0;
    rs1           = '0;
    rs2           = '0;
    condition     = SASA_COND_OR;
    insts_to_skip = '0;
    for (int w = 0; w < SASA_SETS; w++) begin
      if (valid_q[w][pc_idx] && (tag_q[w][pc_idx] == pc_word)) begin
        hit_vec[w]    = 1'b1;
        hit_way       = usage_t'(w);
        rs1           = rs1_q[w][pc_idx];
        rs2           = rs2_q[w][pc_idx];
        condition     = cond_q[w][pc_idx];
        insts_to_skip = cnt_q[w][pc_idx];
      end
    end
  end

  assign hit = |hit_vec;

  // valid bits and lru order
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int w = 0; w < SASA_SETS; w++) begin
        for (int r = 0; r < DEPTH; r++) begin
          valid_q[w][r] <= 1'b0;
          // distinct ages per row, way 0 fills first
          usage_q[w][r] <= usage_t'(SASA_SETS - 1 - w);
        end
      end
    end else if (hit) begin
      for (int w = 0; w < SASA_SETS; w++) begin
        if (usage_t'(w) == hit_way) begin
          usage_q[w][pc_idx] <= '0;
        end else if (usage_q[w][pc_idx] < usage_q[hit_way][pc_idx]) begin
          // only ways younger than the hit way grow older
          usage_q[w][pc_idx] <= usage_q[w][pc_idx] + 1'b1;
        end
      end
    end else if (st_fill) begin
      for (int w = 0; w < SASA_SETS; w++) begin
        if (victim[w]) begin
          valid_q[w][st_idx] <= 1'b1;
          usage_q[w][st_idx] <= '0;
        end else begin
          usage_q[w][st_idx] <= usage_q[w][st_idx] + 1'b1;
        end
      end
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    if (st_fill) begin
      for (int w = 0; w < SASA_SETS; w++) begin
        if (victim[w]) begin
          tag_q[w][st_idx] <= st_prev_pc;
          rs1_q[w][st_idx] <= st_rs1;
          rs2_q[w][st_idx] <= st_rs2;
          cond_q[w][st_idx] <= st_cond;
          cnt_q[w][st_idx] <= st_cnt;
        end
      end
    end
  end

  // a word address lives in one way only, lru fill never duplicates it
  a_single_hit: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(hit_vec));

endmodule

/* sparce_sprf.sv */
// ------------------------------
// register sparsity file, zero flag per register
// ------------------------------
`timescale 1ns/10ps

module sparce_sprf import sparce_cfg_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wb_wen,
  input  reg_idx_t wb_sel,
  input  word_t    wb_data,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output logic     rs1_zero,
  output logic     rs2_zero
);

  // bit i set while register i holds zero
  logic [NUM_REGS-1:0] zero_q;
  logic wb_zero;
  logic wb_live;

  assign wb_zero = (wb_data == '0);
  // x0 is hardwired, writes to it never land
  assign wb_live = wb_wen && (wb_sel != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      // registers come out of reset as zero
      zero_q <= '1;
    end else if (wb_live) begin
      zero_q[wb_sel] <= wb_zero;
    end
  end

  // same-cycle writeback bypass on both read ports
  always_comb begin
    rs1_zero = zero_q[rs1];
    rs2_zero = zero_q[rs2];
    if (wb_live && (wb_sel == rs1)) begin
      rs1_zero = wb_zero;
    end
    if (wb_live && (wb_sel == rs2)) begin
      rs2_zero = wb_zero;
    end
  end

  a_x0_zero: assert property (@(posedge CLK) disable iff (!nRST) zero_q[0]);

endmodule

/* sparce_psru.sv */
// ------------------------------
// skip predictor, condition check and redirect pc
// ------------------------------
`timescale 1ns/10ps

module sparce_psru import sparce_cfg_pkg::*, sparce_sasa_pkg::*; (
  input  logic       sasa_enable,
  input  pc_t        pc,
  input  logic       pc_valid,
  input  logic       hit,
  input  reg_idx_t   sasa_rs1,
  input  reg_idx_t   sasa_rs2,
  input  sasa_cond_t condition,
  input  skip_cnt_t  insts_to_skip,
  input  logic       rs1_zero,
  input  logic       rs2_zero,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output logic       skip,
  output pc_t        skip_pc
);

  logic cond_met;
  pc_t  skip_offset;

  // entry sources go straight to the sparsity read ports
  assign rs1 = sasa_rs1;
  assign rs2 = sasa_rs2;

  // and-type blocks need both sources zero, or-type need either
  assign cond_met = (condition == SASA_COND_AND) ? (rs1_zero && rs2_zero)
                                                 : (rs1_zero || rs2_zero);

  assign skip = pc_valid && sasa_enable && hit && cond_met;

  // the block plus the instruction ahead of it
  assign skip_offset = (pc_t'(insts_to_skip) + pc_t'(1)) * pc_t'(INST_BYTES);

  // plain fall-through when no skip
  assign skip_pc = skip ? (pc + skip_offset) : (pc + pc_t'(INST_BYTES));

  // redirect only comes from a table entry
  always_comb begin
    a_skip_needs_hit: assert (!skip || hit);
  end

endmodule

/* sparce.sv */
// ------------------------------
// sparce skip top: sasa table, sparsity file, predictor
// ------------------------------
`timescale 1ns/10ps

module sparce import sparce_cfg_pkg::*, sparce_sasa_pkg::*; #(
  parameter int  SASA_ENTRIES = 16,
  parameter int  SASA_SETS    = 2,
  parameter pc_t SASA_ADDR    = 32'h1000
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     sasa_enable,
  input  logic     st_wen,
  input  pc_t      st_addr,
  input  word_t    st_data,
  input  logic     wb_wen,
  input  reg_idx_t wb_sel,
  input  word_t    wb_data,
  input  pc_t      pc,
  input  logic     pc_valid,
  output logic     skip,
  output pc_t      skip_pc
);

  // table to predictor
  logic       hit;
  reg_idx_t   sasa_rs1;
  reg_idx_t   sasa_rs2;
  sasa_cond_t condition;
  skip_cnt_t  insts_to_skip;
  // predictor to sparsity file and back
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  logic       rs1_zero;
  logic       rs2_zero;

  sparce_sasa_table #(
    .SASA_ENTRIES (SASA_ENTRIES),
    .SASA_SETS    (SASA_SETS),
    .SASA_ADDR    (SASA_ADDR)
  ) u_sasa_table (
    .CLK           (CLK),
    .nRST          (nRST),
    .sasa_enable   (sasa_enable),
    .st_wen        (st_wen),
    .st_addr       (st_addr),
    .st_data       (st_data),
    .pc            (pc),
    .hit           (hit),
    .rs1           (sasa_rs1),
    .rs2           (sasa_rs2),
    .condition     (condition),
    .insts_to_skip (insts_to_skip)
  );

  sparce_sprf u_sprf (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_wen   (wb_wen),
    .wb_sel   (wb_sel),
    .wb_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_zero (rs1_zero),
    .rs2_zero (rs2_zero)
  );

  sparce_psru u_psru (
    .sasa_enable   (sasa_enable),
    .pc            (pc),
    .pc_valid      (pc_valid),
    .hit           (hit),
    .sasa_rs1      (sasa_rs1),
    .sasa_rs2      (sasa_rs2),
    .condition     (condition),
    .insts_to_skip (insts_to_skip),
    .rs1_zero      (rs1_zero),
    .rs2_zero      (rs2_zero),
    .rs1           (rs1),
    .rs2           (rs2),
    .skip          (skip),
    .skip_pc       (skip_pc)
  );

endmodule

/* tb_sparce.sv */
// ------------------------------
// testbench for the sparce top: reference model, directed tests, watchdog
// ------------------------------
`timescale 1ns/10ps

module tb_sparce import sparce_cfg_pkg::*, sparce_sasa_pkg::*; ();

  // defaults of the DUT, mirrored by the model
  localparam int  WAYS      = 2;
  localparam int  ROWS      = 8;
  localparam pc_t SASA_ADDR = 32'h1000;
  // word address 0xffff is never programmed, so this pc never hits
  localparam pc_t IDLE_PC   = 32'hFFFF_FFFC;
  localparam int  TIMEOUT_NS = 6 * 200 * 10;

  logic     CLK = 1'b0;
  logic     nRST;
  logic     sasa_enable;
  logic     st_wen;
  pc_t      st_addr;
  word_t    st_data;
  logic     wb_wen;
  reg_idx_t wb_sel;
  word_t    wb_data;
  pc_t      pc;
  logic     pc_valid;
  logic     skip;
  pc_t      skip_pc;
  int       seed;

  // reference model state
  logic       m_valid [WAYS][ROWS];
  sasa_pc_t   m_tag   [WAYS][ROWS];
  reg_idx_t   m_rs1   [WAYS][ROWS];
  reg_idx_t   m_rs2   [WAYS][ROWS];
  sasa_cond_t m_cond  [WAYS][ROWS];
  skip_cnt_t  m_cnt   [WAYS][ROWS];
  int         m_use   [WAYS][ROWS];
  logic       m_zero  [32];

  sparce DUT (
    .CLK         (CLK),
    .nRST        (nRST),
    .sasa_enable (sasa_enable),
    .st_wen      (st_wen),
    .st_addr     (st_addr),
    .st_data     (st_data),
    .wb_wen      (wb_wen),
    .wb_sel      (wb_sel),
    .wb_data     (wb_data),
    .pc          (pc),
    .pc_valid    (pc_valid),
    .skip        (skip),
    .skip_pc     (skip_pc)
  );

  always #5 CLK = ~CLK;

  // run ends here if the tests stall
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Regression failed");
    $fatal(1);
  end

  task automatic check_skip(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail skip: got %h expected %h", got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp);
    if (got !== exp) begin
      $display("Fail skip_pc: got %h expected %h", got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  function automatic void model_reset();
    for (int w = 0; w < WAYS; w++) begin
      for (int r = 0; r < ROWS; r++) begin
        m_valid[w][r] = 1'b0;
        // distinct ages so the first victim is well defined
        m_use[w][r] = WAYS - 1 - w;
      end
    end
    for (int i = 0; i < 32; i++) begin
      m_zero[i] = 1'b1;
    end
  endfunction

  // fill the oldest way of the row, age the others
  function automatic void model_fill(input word_t d);
    int r;
    int v;
    r = int'(d[31:16]) % ROWS;
    v = 0;
    for (int w = 0; w < WAYS; w++) begin
      if (m_use[w][r] == WAYS - 1) v = w;
    end
    for (int w = 0; w < WAYS; w++) begin
      if (w == v) begin
        m_valid[w][r] = 1'b1;
        m_tag[w][r] = d[31:16];
        m_rs1[w][r] = d[15:11];
        m_rs2[w][r] = d[10:6];
        m_cond[w][r] = d[5];
        m_cnt[w][r] = d[4:0];
        m_use[w][r] = 0;
      end else begin
        m_use[w][r] = (m_use[w][r] + 1) % WAYS;
      end
    end
  endfunction

  // way holding this pc, -1 on a miss
  function automatic int model_way(input pc_t a);
    sasa_pc_t wd;
    int r;
    wd = a[17:2];
    r = int'(wd) % ROWS;
    model_way = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][r] && (m_tag[w][r] == wd)) model_way = w;
    end
  endfunction

  // hit way becomes newest, only younger ways age
  function automatic void model_touch(input int r, input int hw);
    int hu;
    hu = m_use[hw][r];
    for (int w = 0; w < WAYS; w++) begin
      if (w == hw) m_use[w][r] = 0;
      else if (m_use[w][r] < hu) m_use[w][r] = m_use[w][r] + 1;
    end
  endfunction

  // zero flag as seen in the cycle, including a writeback in flight
  function automatic logic reg_zero(input reg_idx_t idx, input logic wbe,
                                    input reg_idx_t s, input word_t d);
    if (wbe && (s == idx) && (s != 5'd0)) return (d == '0);
    return m_zero[idx];
  endfunction

  function automatic word_t rand_nonzero();
    word_t v;
    v = $random(seed);
    if (v == '0) v = 32'h1;
    return v;
  endfunction

  task automatic snoop_store(input pc_t a, input word_t d, input logic en);
    @(negedge CLK);
    st_wen = 1'b1;
    st_addr = a;
    st_data = d;
    sasa_enable = en;
    @(posedge CLK);
    if (en && (a == SASA_ADDR)) model_fill(d);
    @(negedge CLK);
    st_wen = 1'b0;
    sasa_enable = 1'b1;
  endtask

  task automatic program_entry(input sasa_pc_t prev, input reg_idx_t r1, input reg_idx_t r2,
                               input sasa_cond_t c, input skip_cnt_t n);
    snoop_store(SASA_ADDR, {prev, r1, r2, c, n}, 1'b1);
  endtask

  task automatic write_reg(input reg_idx_t s, input word_t d);
    @(negedge CLK);
    wb_wen = 1'b1;
    wb_sel = s;
    wb_data = d;
    @(posedge CLK);
    if (s != 5'd0) m_zero[s] = (d == '0);
    @(negedge CLK);
    wb_wen = 1'b0;
  endtask

  // one fetch, optionally with a writeback in the same cycle
  task automatic fetch_compare(input pc_t a, input logic v, input logic wbe,
                               input reg_idx_t s, input word_t d);
    int w;
    int r;
    logic z1;
    logic z2;
    logic exp_skip;
    pc_t exp_pc;
    @(negedge CLK);
    pc = a;
    pc_valid = v;
    wb_wen = wbe;
    wb_sel = s;
    wb_data = d;
    w = model_way(a);
    r = int'(a[17:2]) % ROWS;
    exp_skip = 1'b0;
    exp_pc = a + 32'd4;
    if (w >= 0) begin
      z1 = reg_zero(m_rs1[w][r], wbe, s, d);
      z2 = reg_zero(m_rs2[w][r], wbe, s, d);
      exp_skip = v && sasa_enable &&
                 ((m_cond[w][r] == SASA_COND_AND) ? (z1 && z2) : (z1 || z2));
      if (exp_skip) exp_pc = a + pc_t'((int'(m_cnt[w][r]) + 1) * 4);
    end
    @(posedge CLK);
    check_skip(skip, exp_skip);
    check_pc(skip_pc, exp_pc);
    // lookup ages the row even without pc_valid
    if (w >= 0) model_touch(r, w);
    if (wbe && (s != 5'd0)) m_zero[s] = (d == '0);
    @(negedge CLK);
    pc = IDLE_PC;
    pc_valid = 1'b0;
    wb_wen = 1'b0;
  endtask

  task automatic fetch_check(input pc_t a, input logic v);
    fetch_compare(a, v, 1'b0, 5'd0, '0);
  endtask

  // empty table never redirects
  task automatic test_reset_fetch();
    for (int i = 0; i < 4; i++) begin
      fetch_check(pc_t'($random(seed)) & 32'hFFFF_FFFC, 1'b1);
    end
  endtask

  task automatic test_or_entry();
    program_entry(16'h0011, 5'd1, 5'd2, SASA_COND_OR, 5'd5);
    fetch_check(32'h44, 1'b1);
    // one nonzero source still skips
    write_reg(5'd1, rand_nonzero());
    fetch_check(32'h44, 1'b1);
    write_reg(5'd2, rand_nonzero());
    fetch_check(32'h44, 1'b1);
  endtask

  task automatic test_and_entry();
    program_entry(16'h0022, 5'd8, 5'd9, SASA_COND_AND, 5'd3);
    fetch_check(32'h88, 1'b1);
    write_reg(5'd8, rand_nonzero());
    fetch_check(32'h88, 1'b1);
    write_reg(5'd8, '0);
    write_reg(5'd9, rand_nonzero());
    fetch_check(32'h88, 1'b1);
    write_reg(5'd9, '0);
    fetch_check(32'h88, 1'b1);
  endtask

  task automatic test_no_program();
    snoop_store(SASA_ADDR + 32'd4, {16'h0033, 5'd0, 5'd0, SASA_COND_OR, 5'd2}, 1'b1);
    snoop_store(SASA_ADDR, {16'h0033, 5'd0, 5'd0, SASA_COND_OR, 5'd2}, 1'b0);
    fetch_check(32'hCC, 1'b1);
    // x0 as source, so the entry always qualifies
    program_entry(16'h0034, 5'd0, 5'd0, SASA_COND_OR, 5'd4);
    fetch_check(32'hD0, 1'b0);
    fetch_check(32'hD0, 1'b1);
  endtask

  // three tags into row 0 of a 2-way table
  task automatic test_lru();
    program_entry(16'h0040, 5'd0, 5'd0, SASA_COND_OR, 5'd1);
    program_entry(16'h0048, 5'd0, 5'd0, SASA_COND_OR, 5'd2);
    fetch_check(32'h100, 1'b1);
    program_entry(16'h0050, 5'd0, 5'd0, SASA_COND_OR, 5'd3);
    fetch_check(32'h120, 1'b1);
    fetch_check(32'h100, 1'b1);
    fetch_check(32'h140, 1'b1);
  endtask

  task automatic test_wb_bypass();
    program_entry(16'h0035, 5'd6, 5'd7, SASA_COND_OR, 5'd2);
    write_reg(5'd7, rand_nonzero());
    fetch_check(32'hD4, 1'b1);
    fetch_compare(32'hD4, 1'b1, 1'b1, 5'd6, rand_nonzero());
    fetch_check(32'hD4, 1'b1);
  endtask

  initial begin
    seed = 32'h5288_8ee2;
    nRST = 1'b0;
    sasa_enable = 1'b1;
    st_wen = 1'b0;
    st_addr = '0;
    st_data = '0;
    wb_wen = 1'b0;
    wb_sel = '0;
    wb_data = '0;
    pc = IDLE_PC;
    pc_valid = 1'b0;
    model_reset();
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    test_reset_fetch();
    test_or_entry();
    test_and_entry();
    test_no_program();
    test_lru();
    test_wb_bypass();
    $display("Regression passed");
    $finish;
  end

endmodule

/* src.f */
sparce_cfg_pkg.sv
sparce_sasa_pkg.sv
sparce_sasa_table.sv
sparce_sprf.sv
sparce_psru.sv
sparce.sv
tb_sparce.sv

/* Makefile */
# Verilator flow for the sparce skip predictor

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module sparce

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_sparce
	./obj_dir/Vtb_sparce > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
